// ==== all.f ====
verilog/vdec_pkg.sv
verilog/vfield_decode.sv
verilog/vcfg_decode.sv
verilog/vmem_decode.sv
verilog/vopi_decode.sv
verilog/vuop_gen.sv
verilog/vdecode_top.sv
testbench/tb_vdecode.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_vdecode -f all.f \
    -o sim_vdecode > build.log 2>&1 &&
./obj_dir/sim_vdecode > sim.log 2>&1 ||
{ echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "^No errors$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== testbench/tb_vdecode.sv ====
`timescale 1ns/1ps

module tb_vdecode;

    // Expected view of the DUT outputs in one cycle
    typedef struct packed {
        vdec_pkg::vcontrol_t ctl;
        logic                vvalid;
        logic                busy;
    } expect_t;

    localparam logic [31:0] IDLE_WORD = 32'h0000_0013;
    localparam logic [6:0]  OPC_ALU   = 7'b1010111;

    logic                      CLK;
    logic                      nRST;
    vdec_pkg::vinstr_u         instr;
    logic [vdec_pkg::XLEN-1:0] vl;
    vdec_pkg::vsew_t           vsew;
    logic                      stall;
    vdec_pkg::vcontrol_t       vcontrol;
    logic                      vvalid;
    logic                      busy;

    int errors;
    int checks;
    int k_exp;
    int f6_list[11] = '{0, 2, 3, 4, 5, 6, 7, 9, 10, 11, 23};
    int f3_list[5]  = '{0, 3, 4, 2, 6};
    int width_list[3] = '{0, 5, 6};

    vdecode_top UUT (
        .CLK(CLK), .nRST(nRST), .instr(instr), .vl(vl), .vsew(vsew), .stall(stall),
        .vcontrol(vcontrol), .vvalid(vvalid), .busy(busy)
    );

    always #20 CLK = ~CLK;

    task automatic check_val(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Expected outputs for uop k of word w, and the uop count in n
    function automatic expect_t ref_decode(input logic [31:0] w, input int l,
                                           input logic [1:0] sew, input int k,
                                           output int n);
        expect_t    e;
        logic [5:0] f6;
        logic [2:0] f3;
        logic       ld, st, alu, mem, cfg, gen;
        logic       vv, vx, vi, ok, unit, indexed;
        logic [1:0] meew;
        logic [2:0] off;
        int         evl;
        int         p;
        f6  = w[31:26];
        f3  = w[14:12];
        ld  = (w[6:0] == 7'b0000111);
        st  = (w[6:0] == 7'b0100111);
        alu = (w[6:0] == OPC_ALU);
        mem = ld || st;
        cfg = alu && (f3 == 3'b111);
        gen = (mem || alu) && !cfg;
        e   = '0;
        e.vvalid      = mem || alu;
        e.ctl.vvalid  = mem || alu;
        e.ctl.sregwen = cfg;
        e.ctl.vregwen = !cfg && !st;
        // vset* form from bits 31:30
        if (cfg && !w[31]) begin
            e.ctl.vsetvl_type = vdec_pkg::VSETVLI;
            e.ctl.vtype_imm   = w[30:20];
            e.ctl.vkeepvl     = (w[19:15] == 5'd0) && (w[11:7] == 5'd0);
        end else if (cfg && w[30]) begin
            e.ctl.vsetvl_type = vdec_pkg::VSETIVLI;
            e.ctl.vtype_imm   = {1'b0, w[29:20]};
        end else if (cfg) begin
            e.ctl.vsetvl_type = vdec_pkg::VSETVL;
            e.ctl.vkeepvl     = (w[19:15] == 5'd0) && (w[11:7] == 5'd0);
        end
        e.ctl.vimm          = w[19:15];
        e.ctl.vxin1_use_imm = alu && (f3 == 3'd3);
        e.ctl.vxin1_use_rs1 = mem || (alu && (f3 >= 3'd4) && (f3 <= 3'd6));
        // Addressing mode from mop
        unit    = mem && (w[27:26] == 2'd0);
        indexed = mem && w[26];
        e.ctl.vmemdren      = ld;
        e.ctl.vmemdwen      = st;
        e.ctl.vunitstride   = unit;
        e.ctl.vstrided      = mem && (w[27:26] == 2'd2);
        e.ctl.vindexed      = indexed;
        e.ctl.vxin2_use_rs2 = unit || e.ctl.vstrided;
        case (f3)
            3'b000:  meew = 2'd0;
            3'b101:  meew = 2'd1;
            default: meew = 2'd2;
        endcase
        if (!mem) begin
            meew = sew;
        end
        e.ctl.veew_src1 = vdec_pkg::vsew_t'((mem && !indexed) ? meew : sew);
        e.ctl.veew_src2 = vdec_pkg::vsew_t'(indexed ? meew : sew);
        e.ctl.veew_dest = e.ctl.veew_src1;
        // OPI operation table
        vv = (f3 == 3'd0);
        vx = (f3 == 3'd4);
        vi = (f3 == 3'd3);
        ok = 1'b0;
        e.ctl.vexec.valuop = vdec_pkg::VALU_ADD;
        case (f6)
            6'd0: ok = vv || vx || vi;
            6'd2: begin
                e.ctl.vexec.valuop = vdec_pkg::VALU_SUB;
                ok = vv || vx;
            end
            6'd3: begin
                e.ctl.vexec.valuop = vdec_pkg::VALU_RSUB;
                ok = vx || vi;
            end
            6'd4, 6'd5, 6'd6, 6'd7: begin
                e.ctl.vexec.valuop = f6[1] ? vdec_pkg::VALU_MAX : vdec_pkg::VALU_MIN;
                e.ctl.vexec.vopunsigned = !f6[0];
                ok = vv || vx;
            end
            6'd9, 6'd10, 6'd11: begin
                e.ctl.vexec.valuop = (f6 == 6'd9)  ? vdec_pkg::VALU_AND :
                                     (f6 == 6'd10) ? vdec_pkg::VALU_OR : vdec_pkg::VALU_XOR;
                ok = vv || vx || vi;
            end
            6'd23: begin
                e.ctl.vexec.valuop = vdec_pkg::VALU_MERGE;
                ok = (vv || vx || vi) && !w[25];
            end
            default: ok = 1'b0;
        endcase
        ok = ok && alu;
        if (ok) begin
            e.ctl.vsignext = !e.ctl.vexec.vopunsigned;
        end else begin
            e.ctl.vexec.valuop      = vdec_pkg::VALU_ADD;
            e.ctl.vexec.vopunsigned = 1'b0;
        end
        e.ctl.vmask_en = !cfg && !w[25] && !(ok && (f6 == 6'd23));
        // Mask and whole register accesses change the element count
        if (unit && (w[24:20] == 5'b01011)) begin
            evl = (l + 7) / 8;
        end else if (unit && (w[24:20] == 5'b01000)) begin
            evl = ((int'(w[31:29]) + 1) * 16) >> meew;
        end else begin
            evl = l;
        end
        p = (e.ctl.veew_dest == vdec_pkg::SEW8)  ? 4 :
            (e.ctl.veew_dest == vdec_pkg::SEW16) ? 2 : 1;
        n = (evl + 3) / 4;
        if (!gen || (n == 0)) begin
            n = 1;
        end
        off = 3'(k / p);
        e.ctl.vbank_offset = 2'(k % p);
        for (int i = 0; i < 4; i++) begin
            e.ctl.vlaneactive[i] = (4 * k + i) < evl;
        end
        e.ctl.vd_sel    = 5'(w[11:7] + off);
        e.ctl.vs1_sel   = 5'((st ? w[11:7] : w[19:15]) + off);
        e.ctl.vs2_sel   = 5'(w[24:20] + off);
        e.ctl.vuop_num  = 5'(k);
        e.ctl.vuop_last = gen && (k + 1 >= n);
        e.busy          = gen && (k + 1 < n);
        return e;
    endfunction

    // Outputs are settled half a period after the drive edge
    always @(negedge CLK) begin : compare
        expect_t e;
        int      n;
        if (nRST) begin
            e = ref_decode(instr, vl, vsew, k_exp, n);
            check_val(vcontrol, e.ctl, "vcontrol");
            check_val(vvalid, e.vvalid, "vvalid");
            check_val(busy, e.busy, "busy");
            // Uop index moves only on a free cycle
            if (!stall) begin
                k_exp = e.busy ? k_exp + 1 : 0;
            end
        end else begin
            k_exp = 0;
        end
    end

    function automatic logic [31:0] opi_word(input logic [5:0] f6, input logic vm,
                                             input logic [2:0] f3);
        return {f6, vm, 5'($urandom), 5'($urandom), f3, 5'($urandom), OPC_ALU};
    endfunction

    function automatic logic [31:0] mem_word(input logic store, input logic [2:0] nf,
                                             input logic [1:0] mop, input logic [4:0] lumop);
        logic [2:0] width;
        width = 3'(width_list[$urandom % 3]);
        return {nf, 1'b0, mop, 1'($urandom), lumop, 5'($urandom), width, 5'($urandom),
                store ? 7'b0100111 : 7'b0000111};
    endfunction

    // Present one word until its last free cycle, stalling pct percent of cycles
    task automatic issue(input logic [31:0] w, input int l, input int s, input int pct);
        int      n;
        int      steps;
        int      cycles;
        bit      done;
        void'(ref_decode(w, l, s[1:0], 0, n));
        steps  = 0;
        cycles = 0;
        done   = 1'b0;
        @(posedge CLK);
        instr <= w;
        vl    <= l;
        vsew  <= vdec_pkg::vsew_t'(s);
        stall <= ($urandom % 100) < pct;
        while (!done && (cycles < 400)) begin
            @(negedge CLK);
            cycles++;
            if (!stall) begin
                steps++;
                done = !busy;
            end
            if (!done) begin
                @(posedge CLK);
                stall <= ($urandom % 100) < pct;
            end
        end
        if (!done) begin
            errors++;
            $display("Timeout at %0t: instruction %h never reached its last uop", $time, w);
        end else begin
            check_val(steps, n, "uop count");
        end
    endtask

    initial begin
        int s;
        void'($urandom(9));
        CLK    = 1'b0;
        nRST   = 1'b0;
        instr  = IDLE_WORD;
        vl     = '0;
        vsew   = vdec_pkg::SEW8;
        stall  = 1'b0;
        errors = 0;
        checks = 0;
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;

        // vsetvli keep and set, vsetivli, vsetvl keep and set
        issue({1'b0, 11'($urandom), 5'd0, 3'b111, 5'd0, OPC_ALU}, 20, 0, 0);
        issue({1'b0, 11'($urandom), 5'd3, 3'b111, 5'd4, OPC_ALU}, 20, 1, 0);
        issue({2'b11, 10'($urandom), 5'($urandom), 3'b111, 5'($urandom), OPC_ALU}, 7, 2, 0);
        issue({7'b1000000, 5'($urandom), 5'd0, 3'b111, 5'd0, OPC_ALU}, 3, 0, 30);
        issue({7'b1000000, 5'($urandom), 5'd7, 3'b111, 5'd1, OPC_ALU}, 3, 0, 30);

        // Fixed OPI corner cases: RSUB VV, merge, unmasked merge
        issue(opi_word(6'b000011, 1'b1, 3'd0), 9, 0, 0);
        issue(opi_word(6'b010111, 1'b0, 3'd3), 17, 1, 0);
        issue(opi_word(6'b010111, 1'b1, 3'd0), 17, 1, 0);
        issue(opi_word(6'b000000, 1'b1, 3'd0), 0, 2, 0);

        // Random OPI words with random vl and vsew, then with stalls
        for (int t = 0; t < 60; t++) begin
            s = $urandom % 3;
            issue(opi_word(6'(f6_list[$urandom % 11]), 1'($urandom),
                           3'(f3_list[$urandom % 5])),
                  $urandom % ((128 >> s) + 1), s, (t < 30) ? 0 : 40);
        end

        // Each mop for loads and stores
        for (int mop = 0; mop < 4; mop++) begin
            for (int store = 0; store < 2; store++) begin
                issue(mem_word(1'(store), 3'd0, 2'(mop), (mop == 0) ? 5'd0 : 5'($urandom)),
                      $urandom % 33, $urandom % 3, 20);
            end
        end

        // Mask and whole register accesses
        for (int t = 0; t < 8; t++) begin
            issue(mem_word(1'($urandom), 3'd0, 2'd0, 5'b01011), $urandom % 129,
                  $urandom % 3, 20);
            issue(mem_word(1'($urandom), 3'($urandom), 2'd0, 5'b01000), $urandom % 33,
                  $urandom % 3, 20);
        end

        issue(IDLE_WORD, 0, 0, 0);
        issue(IDLE_WORD, 0, 0, 0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verilog/vcfg_decode.sv ====
`timescale 1ns/1ps

module vcfg_decode (
    input  vdec_pkg::vinstr_u      instr,
    input  logic                   is_cfg,
    output vdec_pkg::vsetvl_type_t vsetvl_type,
    output logic [10:0]            vtype_imm,
    output logic                   vkeepvl
);

    logic rs1_rd_zero;

    // rs1 = x0 and rd = x0 keeps the current vl
    assign rs1_rd_zero = (instr.alu.vs1 == 5'd0) && (instr.alu.vd == 5'd0);

    always_comb begin
        vsetvl_type = vdec_pkg::NOT_CFG;
        vtype_imm   = '0;
        vkeepvl     = 1'b0;
        if (is_cfg) begin
            casez (instr[31:30])
                2'b0?: begin
                    // vsetvli has an 11 bit vtype
                    vsetvl_type = vdec_pkg::VSETVLI;
                    vtype_imm   = instr[30:20];
                    vkeepvl     = rs1_rd_zero;
                end
                2'b11: begin
                    // vsetivli, avl comes from the rs1 field
                    vsetvl_type = vdec_pkg::VSETIVLI;
                    vtype_imm   = {1'b0, instr[29:20]};
                end
                default: begin
                    // vsetvl takes vtype from rs2
                    vsetvl_type = vdec_pkg::VSETVL;
                    vkeepvl     = rs1_rd_zero;
                end
            endcase
        end
    end

endmodule

// ==== verilog/vdec_pkg.sv ====
package vdec_pkg;

    // Core and vector unit geometry
    localparam int XLEN      = 32;
    localparam int VLENB     = 16;
    localparam int NUM_LANES = 4;
    localparam int MAX_LMUL  = 8;
    localparam int UOP_NUM_W = 5;

    // Major opcodes of the vector extension
    typedef enum logic [6:0] {
        VMOC_LOAD    = 7'b0000111,
        VMOC_STORE   = 7'b0100111,
        VMOC_ALU_CFG = 7'b1010111,
        VMOC_INVALID = 7'b1111111
    } vmajoropcode_t;

    // Operand format, or vset* when OPCFG
    typedef enum logic [2:0] {
        OPIVV, OPFVV, OPMVV, OPIVI, OPIVX, OPFVF, OPMVX, OPCFG
    } vfunct3_t;

    typedef enum logic [1:0] {SEW8, SEW16, SEW32} vsew_t;

    // Memory width codes
    typedef enum logic [2:0] {
        WIDTH8  = 3'b000,
        WIDTH16 = 3'b101,
        WIDTH32 = 3'b110
    } width_t;

    typedef enum logic [1:0] {
        MOP_UNIT, MOP_UINDEXED, MOP_STRIDED, MOP_OINDEXED
    } mop_t;

    // Unit stride variants
    typedef enum logic [4:0] {
        LUMOP_UNIT         = 5'b00000,
        LUMOP_UNIT_FULLREG = 5'b01000,
        LUMOP_UNIT_MASK    = 5'b01011
    } lumop_t;

    // Supported OPI funct6 values
    typedef enum logic [5:0] {
        VADD   = 6'b000000,
        VSUB   = 6'b000010,
        VRSUB  = 6'b000011,
        VMINU  = 6'b000100,
        VMIN   = 6'b000101,
        VMAXU  = 6'b000110,
        VMAX   = 6'b000111,
        VAND   = 6'b001001,
        VOR    = 6'b001010,
        VXOR   = 6'b001011,
        VMERGE = 6'b010111
    } vopi_t;

    typedef enum logic [3:0] {
        VALU_ADD, VALU_SUB, VALU_RSUB, VALU_AND, VALU_OR,
        VALU_XOR, VALU_MIN, VALU_MAX, VALU_MERGE
    } valuop_t;

    typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} vsetvl_type_t;

    typedef struct packed {
        valuop_t valuop;
        logic    vopunsigned;
    } vexec_t;

    // One instruction word, read as arithmetic or as memory format
    typedef union packed {
        struct packed {
            logic [5:0] funct6;
            logic       vm;
            logic [4:0] vs2;
            logic [4:0] vs1;
            vfunct3_t   funct3;
            logic [4:0] vd;
            logic [6:0] opcode;
        } alu;
        struct packed {
            logic [2:0] nf;
            logic       mew;
            mop_t       mop;
            logic       vm;
            logic [4:0] lumop;
            logic [4:0] rs1;
            logic [2:0] width;
            logic [4:0] vd;
            logic [6:0] opcode;
        } mem;
    } vinstr_u;

    typedef struct packed {
        logic                 vvalid;
        logic                 sregwen;
        logic                 vregwen;
        vsetvl_type_t         vsetvl_type;
        logic [10:0]          vtype_imm;
        logic                 vkeepvl;
        logic [4:0]           vimm;
        logic                 vxin1_use_imm;
        logic                 vxin1_use_rs1;
        logic                 vxin2_use_rs2;
        logic                 vmemdren;
        logic                 vmemdwen;
        logic                 vunitstride;
        logic                 vstrided;
        logic                 vindexed;
        vsew_t                veew_src1;
        vsew_t                veew_src2;
        vsew_t                veew_dest;
        vexec_t               vexec;
        logic                 vsignext;
        logic                 vmask_en;
        logic [4:0]           vd_sel;
        logic [4:0]           vs1_sel;
        logic [4:0]           vs2_sel;
        logic [UOP_NUM_W-1:0] vuop_num;
        logic [1:0]           vbank_offset;
        logic [NUM_LANES-1:0] vlaneactive;
        logic                 vuop_last;
    } vcontrol_t;

endpackage

// ==== verilog/vdecode_top.sv ====
`timescale 1ns/1ps

module vdecode_top (
    input  logic                      CLK,
    input  logic                      nRST,
    input  vdec_pkg::vinstr_u         instr,
    input  logic [vdec_pkg::XLEN-1:0] vl,
    input  vdec_pkg::vsew_t           vsew,
    input  logic                      stall,
    output vdec_pkg::vcontrol_t       vcontrol,
    output logic                      vvalid,
    output logic                      busy
);

    vdec_pkg::vmajoropcode_t vmajoropcode;
    vdec_pkg::vfunct3_t      vfunct3;
    vdec_pkg::vsetvl_type_t  vsetvl_type;
    vdec_pkg::vsew_t         vmem_eew;
    vdec_pkg::vexec_t        vexec_opi;
    logic                    vmajoropcode_valid;
    logic                    is_cfg;
    logic                    vencmasken;
    logic [4:0]              vd;
    logic [4:0]              vs1;
    logic [4:0]              vs2;
    logic [10:0]             vtype_imm;
    logic                    vkeepvl;
    logic                    vmemdren;
    logic                    vmemdwen;
    logic                    vunitstride;
    logic                    vstrided;
    logic                    vindexed;
    logic                    vmeminstr;
    logic [vdec_pkg::XLEN-1:0] evl;
    logic                    vopi_decode_valid;
    logic                    vopi_disable_mask;
    logic                    vopi_valid;
    logic                    is_alu;
    logic [vdec_pkg::UOP_NUM_W-1:0] vuop_num;
    logic [2:0]              vreg_offset;
    logic [1:0]              vbank_offset;
    logic [vdec_pkg::NUM_LANES-1:0] vlane_active;
    logic                    vuop_last;
    logic                    vgen_uops;
    vdec_pkg::vsew_t         veew_dest;

    vfield_decode u_field (
        .instr(instr), .vmajoropcode(vmajoropcode),
        .vmajoropcode_valid(vmajoropcode_valid), .vfunct3(vfunct3), .is_cfg(is_cfg),
        .vd(vd), .vs1(vs1), .vs2(vs2), .vencmasken(vencmasken)
    );

    vcfg_decode u_cfg (
        .instr(instr), .is_cfg(is_cfg), .vsetvl_type(vsetvl_type),
        .vtype_imm(vtype_imm), .vkeepvl(vkeepvl)
    );

    vmem_decode u_mem (
        .instr(instr), .vmajoropcode(vmajoropcode), .vl(vl), .vsew(vsew),
        .vmemdren(vmemdren), .vmemdwen(vmemdwen), .vunitstride(vunitstride),
        .vstrided(vstrided), .vindexed(vindexed), .vmem_eew(vmem_eew), .evl(evl)
    );

    vopi_decode u_opi (
        .instr(instr), .vfunct3(vfunct3), .vexec(vexec_opi),
        .valid(vopi_decode_valid), .disable_mask(vopi_disable_mask)
    );

    // Every valid vector instruction except vset* is split into uops
    assign vgen_uops = vmajoropcode_valid && !is_cfg;

    vuop_gen u_gen (
        .CLK(CLK), .nRST(nRST), .gen(vgen_uops), .stall(stall), .veew(veew_dest),
        .evl(evl), .vuop_num(vuop_num), .vreg_offset(vreg_offset),
        .vbank_offset(vbank_offset), .vlane_active(vlane_active),
        .vuop_last(vuop_last), .busy(busy)
    );

    assign is_alu     = (vmajoropcode == vdec_pkg::VMOC_ALU_CFG);
    assign vopi_valid = is_alu && vopi_decode_valid;
    assign vmeminstr  = vmemdren || vmemdwen;
    assign vvalid     = vmajoropcode_valid;

    // Memory width overrides vsew on the data side, or on the index side
    assign veew_dest = (vmeminstr && !vindexed) ? vmem_eew : vsew;

    always_comb begin
        vcontrol.vvalid      = vmajoropcode_valid;
        vcontrol.sregwen     = is_cfg;
        vcontrol.vregwen     = !is_cfg && !vmemdwen;
        vcontrol.vsetvl_type = vsetvl_type;
        vcontrol.vtype_imm   = vtype_imm;
        vcontrol.vkeepvl     = vkeepvl;
        vcontrol.vimm        = vs1;

        // Operand sources
        vcontrol.vxin1_use_imm = is_alu && (vfunct3 == vdec_pkg::OPIVI);
        vcontrol.vxin1_use_rs1 = vmeminstr ||
                                 (is_alu && ((vfunct3 == vdec_pkg::OPIVX) ||
                                             (vfunct3 == vdec_pkg::OPFVF) ||
                                             (vfunct3 == vdec_pkg::OPMVX)));
        vcontrol.vxin2_use_rs2 = vunitstride || vstrided;

        vcontrol.vmemdren    = vmemdren;
        vcontrol.vmemdwen    = vmemdwen;
        vcontrol.vunitstride = vunitstride;
        vcontrol.vstrided    = vstrided;
        vcontrol.vindexed    = vindexed;

        vcontrol.veew_src1 = (vmeminstr && !vindexed) ? vmem_eew : vsew;
        vcontrol.veew_src2 = vindexed ? vmem_eew : vsew;
        vcontrol.veew_dest = veew_dest;

        // Address generation of loads and stores runs on the ALU as ADD
        vcontrol.vexec.valuop      = vdec_pkg::VALU_ADD;
        vcontrol.vexec.vopunsigned = 1'b0;
        vcontrol.vsignext          = 1'b0;
        if (vopi_valid) begin
            vcontrol.vexec    = vexec_opi;
            vcontrol.vsignext = !vexec_opi.vopunsigned;
        end

        vcontrol.vmask_en = vencmasken && !(vopi_valid && vopi_disable_mask);

        // Register selects step through the register group, store data in vs3
        vcontrol.vd_sel  = vd + {2'b00, vreg_offset};
        vcontrol.vs1_sel = (vmemdwen ? vd : vs1) + {2'b00, vreg_offset};
        vcontrol.vs2_sel = vs2 + {2'b00, vreg_offset};

        vcontrol.vuop_num     = vuop_num;
        vcontrol.vbank_offset = vbank_offset;
        vcontrol.vlaneactive  = vlane_active;
        vcontrol.vuop_last    = vuop_last;
    end

    // Instruction word is held for the whole uop sequence
    assert property (@(posedge CLK) disable iff (!nRST)
        busy |=> $stable(instr));

endmodule

// ==== verilog/vfield_decode.sv ====
`timescale 1ns/1ps

module vfield_decode (
    input  vdec_pkg::vinstr_u       instr,
    output vdec_pkg::vmajoropcode_t vmajoropcode,
    output logic                    vmajoropcode_valid,
    output vdec_pkg::vfunct3_t      vfunct3,
    output logic                    is_cfg,
    output logic [4:0]              vd,
    output logic [4:0]              vs1,
    output logic [4:0]              vs2,
    output logic                    vencmasken
);

    // Opcode sits in the same place in both views
    always_comb begin
        vmajoropcode_valid = 1'b1;
        case (instr.alu.opcode)
            vdec_pkg::VMOC_LOAD:    vmajoropcode = vdec_pkg::VMOC_LOAD;
            vdec_pkg::VMOC_STORE:   vmajoropcode = vdec_pkg::VMOC_STORE;
            vdec_pkg::VMOC_ALU_CFG: vmajoropcode = vdec_pkg::VMOC_ALU_CFG;
            default: begin
                // Not a vector instruction
                vmajoropcode       = vdec_pkg::VMOC_INVALID;
                vmajoropcode_valid = 1'b0;
            end
        endcase
    end

    // Format field, only meaningful for the arithmetic class
    assign vfunct3 = instr.alu.funct3;

    // vset* shares the arithmetic opcode
    assign is_cfg = (vmajoropcode == vdec_pkg::VMOC_ALU_CFG) &&
                    (vfunct3 == vdec_pkg::OPCFG);

    // Register fields
    // vd doubles as vs3 for stores
    assign vd  = instr.alu.vd;
    assign vs1 = instr.alu.vs1;
    assign vs2 = instr.alu.vs2;

    // vm low means masked by v0
    assign vencmasken = !is_cfg && !instr.alu.vm;

endmodule

// ==== verilog/vmem_decode.sv ====
`timescale 1ns/1ps

module vmem_decode (
    input  vdec_pkg::vinstr_u       instr,
    input  vdec_pkg::vmajoropcode_t vmajoropcode,
    input  logic [vdec_pkg::XLEN-1:0] vl,
    input  vdec_pkg::vsew_t         vsew,
    output logic                    vmemdren,
    output logic                    vmemdwen,
    output logic                    vunitstride,
    output logic                    vstrided,
    output logic                    vindexed,
    output vdec_pkg::vsew_t         vmem_eew,
    output logic [vdec_pkg::XLEN-1:0] evl
);

    logic                      vmeminstr;
    logic                      vmaskldst;
    logic                      vwholereg;
    vdec_pkg::vsew_t           width_eew;
    logic [vdec_pkg::XLEN-1:0] nf_regs;
    logic [vdec_pkg::XLEN-1:0] mask_evl;
    logic [vdec_pkg::XLEN-1:0] wholereg_evl;

    assign vmemdren  = (vmajoropcode == vdec_pkg::VMOC_LOAD);
    assign vmemdwen  = (vmajoropcode == vdec_pkg::VMOC_STORE);
    assign vmeminstr = vmemdren || vmemdwen;

    // Addressing mode
    assign vunitstride = vmeminstr && (instr.mem.mop == vdec_pkg::MOP_UNIT);
    assign vstrided    = vmeminstr && (instr.mem.mop == vdec_pkg::MOP_STRIDED);
    assign vindexed    = vmeminstr && ((instr.mem.mop == vdec_pkg::MOP_UINDEXED) ||
                                       (instr.mem.mop == vdec_pkg::MOP_OINDEXED));

    // Element width from the width field, wider codes fold to 32
    always_comb begin
        case (vdec_pkg::width_t'(instr.mem.width))
            vdec_pkg::WIDTH8:  width_eew = vdec_pkg::SEW8;
            vdec_pkg::WIDTH16: width_eew = vdec_pkg::SEW16;
            default:           width_eew = vdec_pkg::SEW32;
        endcase
    end

    assign vmem_eew = vmeminstr ? width_eew : vsew;

    // lumop only has meaning for unit stride
    assign vmaskldst = vunitstride && (instr.mem.lumop == vdec_pkg::LUMOP_UNIT_MASK);
    assign vwholereg = vunitstride && (instr.mem.lumop == vdec_pkg::LUMOP_UNIT_FULLREG);

    // Mask access moves ceil(vl/8) bytes
    assign mask_evl = (vl >> 3) + {{(vdec_pkg::XLEN-1){1'b0}}, |vl[2:0]};

    // Whole register: nf+1 registers of VLENB bytes, counted in eew elements
    assign nf_regs      = {{(vdec_pkg::XLEN-3){1'b0}}, instr.mem.nf} + 1;
    assign wholereg_evl = (nf_regs * vdec_pkg::VLENB) >> vmem_eew;

    assign evl = vmaskldst ? mask_evl :
                 vwholereg ? wholereg_evl :
                             vl;

endmodule

// ==== verilog/vopi_decode.sv ====
`timescale 1ns/1ps

module vopi_decode (
    input  vdec_pkg::vinstr_u  instr,
    input  vdec_pkg::vfunct3_t vfunct3,
    output vdec_pkg::vexec_t   vexec,
    output logic               valid,
    output logic               disable_mask
);

    logic is_vv;
    logic is_vx;
    logic is_vi;

    assign is_vv = (vfunct3 == vdec_pkg::OPIVV);
    assign is_vx = (vfunct3 == vdec_pkg::OPIVX);
    assign is_vi = (vfunct3 == vdec_pkg::OPIVI);

    always_comb begin
        vexec.valuop      = vdec_pkg::VALU_ADD;
        vexec.vopunsigned = 1'b0;
        valid             = 1'b0;
        disable_mask      = 1'b0;
        case (vdec_pkg::vopi_t'(instr.alu.funct6))
            vdec_pkg::VADD: begin
                valid = is_vv || is_vx || is_vi;
            end
            vdec_pkg::VSUB: begin
                vexec.valuop = vdec_pkg::VALU_SUB;
                valid        = is_vv || is_vx;
            end
            vdec_pkg::VRSUB: begin
                // Reverse sub has no VV form
                vexec.valuop = vdec_pkg::VALU_RSUB;
                valid        = is_vx || is_vi;
            end
            vdec_pkg::VMINU, vdec_pkg::VMIN: begin
                vexec.valuop      = vdec_pkg::VALU_MIN;
                vexec.vopunsigned = !instr.alu.funct6[0];
                valid             = is_vv || is_vx;
            end
            vdec_pkg::VMAXU, vdec_pkg::VMAX: begin
                vexec.valuop      = vdec_pkg::VALU_MAX;
                vexec.vopunsigned = !instr.alu.funct6[0];
                valid             = is_vv || is_vx;
            end
            vdec_pkg::VAND: begin
                vexec.valuop = vdec_pkg::VALU_AND;
                valid        = is_vv || is_vx || is_vi;
            end
            vdec_pkg::VOR: begin
                vexec.valuop = vdec_pkg::VALU_OR;
                valid        = is_vv || is_vx || is_vi;
            end
            vdec_pkg::VXOR: begin
                vexec.valuop = vdec_pkg::VALU_XOR;
                valid        = is_vv || is_vx || is_vi;
            end
            vdec_pkg::VMERGE: begin
                // v0 selects the source, so no masking of the write
                vexec.valuop = vdec_pkg::VALU_MERGE;
                valid        = (is_vv || is_vx || is_vi) && !instr.alu.vm;
                disable_mask = 1'b1;
            end
            default: begin
                valid = 1'b0;
            end
        endcase
    end

endmodule

// ==== verilog/vuop_gen.sv ====
`timescale 1ns/1ps

module vuop_gen (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            gen,
    input  logic                            stall,
    input  vdec_pkg::vsew_t                 veew,
    input  logic [vdec_pkg::XLEN-1:0]       evl,
    output logic [vdec_pkg::UOP_NUM_W-1:0]  vuop_num,
    output logic [2:0]                      vreg_offset,
    output logic [1:0]                      vbank_offset,
    output logic [vdec_pkg::NUM_LANES-1:0]  vlane_active,
    output logic                            vuop_last,
    output logic                            busy
);

    logic [vdec_pkg::XLEN-1:0] uop_total;
    logic [vdec_pkg::XLEN-1:0] uop_idx;
    logic [vdec_pkg::XLEN-1:0] elem_base;
    logic                      last;

    // ceil(evl / NUM_LANES)
    assign uop_total = (evl >> $clog2(vdec_pkg::NUM_LANES)) +
                       {{(vdec_pkg::XLEN-1){1'b0}},
                        |(evl & (vdec_pkg::NUM_LANES - 1))};

    assign uop_idx = {{(vdec_pkg::XLEN-vdec_pkg::UOP_NUM_W){1'b0}}, vuop_num};

    // Also true on uop 0 when evl is zero
    assign last = (uop_idx + 1) >= uop_total;

    assign vuop_last = gen && last;
    assign busy      = gen && !last;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vuop_num <= '0;
        end else if (!stall) begin
            if (busy) begin
                vuop_num <= vuop_num + 1'b1;
            end else begin
                vuop_num <= '0;
            end
        end
    end

    // Uops per register is 4, 2 or 1 by element width
    always_comb begin
        case (veew)
            vdec_pkg::SEW8: begin
                vreg_offset  = vuop_num[4:2];
                vbank_offset = vuop_num[1:0];
            end
            vdec_pkg::SEW16: begin
                vreg_offset  = vuop_num[3:1];
                vbank_offset = {1'b0, vuop_num[0]};
            end
            default: begin
                vreg_offset  = vuop_num[2:0];
                vbank_offset = 2'b00;
            end
        endcase
    end

    // Lane i is live while its element index is below evl
    assign elem_base = uop_idx * vdec_pkg::NUM_LANES;

    always_comb begin
        for (int i = 0; i < vdec_pkg::NUM_LANES; i++) begin
            vlane_active[i] = (elem_base + i) < evl;
        end
    end

    // The decoded evl never spans more than MAX_LMUL registers
    assert property (@(posedge CLK) disable iff (!nRST)
        gen |-> uop_total <= vdec_pkg::MAX_LMUL * 4);

    // Sequence length and offsets rely on evl and eew holding until the last uop
    assert property (@(posedge CLK) disable iff (!nRST)
        busy |=> $stable(evl) && $stable(veew));

endmodule
